// File: Makefile
TOOL      = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tb_cpu
FILE_LIST = list.f
BUILD_DIR = obj_dir
PASS_MSG  = Simulation passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the core and testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: common/cpu_defs.svh
// widths, reset vector, opcode and function fields, ALU operation codes
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

`define WORD_W      32
`define REG_AW      5
`define RESET_PC    32'hbfc0_0000       // boot rom base

`define OP_SPECIAL  6'h00               // R-type, function field selects
`define OP_BEQ      6'h04
`define OP_BNE      6'h05
`define OP_ADDIU    6'h09
`define OP_ORI      6'h0d
`define OP_LUI      6'h0f
`define OP_LW       6'h23
`define OP_SW       6'h2b

`define FN_ADDU     6'h21
`define FN_SUBU     6'h23
`define FN_AND      6'h24
`define FN_OR       6'h25
`define FN_SLT      6'h2a

`define ALU_ADD     3'd0
`define ALU_SUB     3'd1
`define ALU_AND     3'd2
`define ALU_OR      3'd3
`define ALU_SLT     3'd4                // signed compare
`define ALU_LUI     3'd5                // operand b into upper half

`endif

// File: common/cpu_pkg.sv
// shared vector types for data words, register numbers and ALU operations
`include "cpu_defs.svh"

package cpu_pkg;

    // any data value, address or instruction
    typedef logic [`WORD_W-1:0] word_t;

    // register file index
    typedef logic [`REG_AW-1:0] reg_addr_t;

    // one of the ALU_* codes
    typedef logic [2:0]         alu_op_t;

endpackage

// File: common/pipe_ifs.sv
// decode-to-execute, execute-to-memory and writeback bus interfaces
`timescale 1ns/1ps

interface id_ex_if;
    import cpu_pkg::*;

    logic      valid;
    word_t     pc;
    reg_addr_t rs;            // source numbers for forwarding
    reg_addr_t rt;
    reg_addr_t dest;          // rd or rt, already chosen
    word_t     a;             // register file operands
    word_t     b;
    word_t     imm;           // extended immediate
    alu_op_t   alu_op;
    logic      use_imm;
    logic      reg_write;
    logic      mem_read;
    logic      mem_write;
    logic      branch_eq;
    logic      branch_ne;

    modport src (output valid, pc, rs, rt, dest, a, b, imm, alu_op, use_imm,
                 reg_write, mem_read, mem_write, branch_eq, branch_ne);
    modport dst (input  valid, pc, rs, rt, dest, a, b, imm, alu_op, use_imm,
                 reg_write, mem_read, mem_write, branch_eq, branch_ne);
endinterface

interface ex_mem_if;
    import cpu_pkg::*;

    logic      valid;
    word_t     pc;
    word_t     result;        // ALU result, also the data address
    word_t     store_data;
    reg_addr_t dest;
    logic      reg_write;
    logic      mem_read;
    logic      mem_write;

    modport src (output valid, pc, result, store_data, dest, reg_write, mem_read, mem_write);
    modport dst (input  valid, pc, result, store_data, dest, reg_write, mem_read, mem_write);
endinterface

interface wb_bus_if;
    import cpu_pkg::*;

    logic      valid;
    reg_addr_t dest;
    word_t     result;
    logic      reg_write;

    modport src (output valid, dest, result, reg_write);
    modport dst (input  valid, dest, result, reg_write);
endinterface

// File: decode/decode_stage.sv
// instruction decode, operand read and decode-to-execute register
`timescale 1ns/1ps
`include "cpu_defs.svh"

module decode_stage (
    input  logic               aclk,
    input  logic               rst_n,
    input  logic               stall,
    input  logic               flush,
    input  logic               if_valid,
    input  cpu_pkg::word_t     if_pc,
    input  cpu_pkg::word_t     if_instr,
    wb_bus_if.dst              wb,
    id_ex_if.src               ex,
    output cpu_pkg::reg_addr_t id_rs,
    output cpu_pkg::reg_addr_t id_rt,
    output logic               id_use_rs,
    output logic               id_use_rt
);
    import cpu_pkg::*;

    logic [5:0] op;
    logic [5:0] fn;
    reg_addr_t  rd;
    reg_addr_t  dest;
    word_t      imm;
    word_t      rdata_a;
    word_t      rdata_b;
    alu_op_t    alu_op;
    logic       use_imm;
    logic       sign_ext;
    logic       dst_rd;
    logic       reg_write;
    logic       mem_read;
    logic       mem_write;
    logic       br_eq;
    logic       br_ne;
    logic       use_rs;
    logic       use_rt;
    logic       go;

    assign op    = if_instr[31:26];
    assign id_rs = if_instr[25:21];
    assign id_rt = if_instr[20:16];
    assign rd    = if_instr[15:11];
    assign fn    = if_instr[5:0];

    always_comb begin
        alu_op    = `ALU_ADD;
        use_imm   = 1'b1;
        sign_ext  = 1'b1;
        dst_rd    = 1'b0;
        reg_write = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        br_eq     = 1'b0;
        br_ne     = 1'b0;
        use_rs    = 1'b1;
        use_rt    = 1'b0;
        case (op)
            `OP_SPECIAL: begin
                use_imm   = 1'b0;
                dst_rd    = 1'b1;
                use_rt    = 1'b1;
                reg_write = 1'b1;
                case (fn)
                    `FN_ADDU: alu_op = `ALU_ADD;
                    `FN_SUBU: alu_op = `ALU_SUB;
                    `FN_AND:  alu_op = `ALU_AND;
                    `FN_OR:   alu_op = `ALU_OR;
                    `FN_SLT:  alu_op = `ALU_SLT;
                    default: begin                         // unknown function, no-op
                        reg_write = 1'b0;
                        use_rs    = 1'b0;
                        use_rt    = 1'b0;
                    end
                endcase
            end
            `OP_ADDIU: reg_write = 1'b1;
            `OP_ORI: begin
                alu_op    = `ALU_OR;
                sign_ext  = 1'b0;
                reg_write = 1'b1;
            end
            `OP_LUI: begin
                alu_op    = `ALU_LUI;
                use_rs    = 1'b0;
                reg_write = 1'b1;
            end
            `OP_LW: begin
                mem_read  = 1'b1;
                reg_write = 1'b1;
            end
            `OP_SW: begin
                mem_write = 1'b1;
                use_rt    = 1'b1;                          // store data
            end
            `OP_BEQ, `OP_BNE: begin
                use_imm = 1'b0;
                use_rt  = 1'b1;
                br_eq   = (op == `OP_BEQ);
                br_ne   = (op == `OP_BNE);
            end
            default:   use_rs = 1'b0;                    // unknown opcode, no-op
        endcase
    end

    assign imm       = sign_ext ? {{16{if_instr[15]}}, if_instr[15:0]} : {16'b0, if_instr[15:0]};
    assign dest      = dst_rd ? rd : id_rt;
    assign id_use_rs = if_valid && use_rs;
    assign id_use_rt = if_valid && use_rt;
    assign go        = if_valid && !stall && !flush;     // otherwise a bubble

    reg_file u_regs (
        .aclk, .rst_n,
        .ra (id_rs),
        .rb (id_rt),
        .wa (wb.dest),
        .we (wb.valid && wb.reg_write),
        .wd (wb.result),
        .da (rdata_a),
        .db (rdata_b)
    );

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            ex.valid     <= 1'b0;
            ex.reg_write <= 1'b0;
            ex.mem_read  <= 1'b0;
            ex.mem_write <= 1'b0;
            ex.branch_eq <= 1'b0;
            ex.branch_ne <= 1'b0;
        end else begin
            ex.valid     <= go;
            ex.reg_write <= go && reg_write && (dest != '0);   // r0 never written
            ex.mem_read  <= go && mem_read;
            ex.mem_write <= go && mem_write;
            ex.branch_eq <= go && br_eq;
            ex.branch_ne <= go && br_ne;
        end
    end

    always_ff @(posedge aclk) begin
        ex.pc      <= if_pc;
        ex.rs      <= id_rs;
        ex.rt      <= id_rt;
        ex.dest    <= dest;
        ex.a       <= rdata_a;
        ex.b       <= rdata_b;
        ex.imm     <= imm;
        ex.alu_op  <= alu_op;
        ex.use_imm <= use_imm;
    end

endmodule

// File: decode/reg_file.sv
// 32-entry register file, two async read ports with write bypass
`timescale 1ns/1ps
`include "cpu_defs.svh"

module reg_file (
    input  logic               aclk,
    input  logic               rst_n,
    input  cpu_pkg::reg_addr_t ra,
    input  cpu_pkg::reg_addr_t rb,
    input  cpu_pkg::reg_addr_t wa,
    input  logic               we,
    input  cpu_pkg::word_t     wd,
    output cpu_pkg::word_t     da,
    output cpu_pkg::word_t     db
);
    import cpu_pkg::*;

    localparam int NREG = 1 << `REG_AW;

    word_t regs [NREG];

    // r0 reads zero and a write in this cycle is seen at once
    function automatic word_t read_port(reg_addr_t addr);
        if (addr == '0)
            return '0;
        else if (we && (wa == addr))
            return wd;
        else
            return regs[addr];
    endfunction

    always_comb begin
        da = read_port(ra);
        db = read_port(rb);
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NREG; i++)
                regs[i] <= '0;
        end else if (we && (wa != '0)) begin
            regs[wa] <= wd;
        end
    end

endmodule

// File: execute/execute_stage.sv
// operand forwarding, ALU, branch resolve and execute-to-memory register
`timescale 1ns/1ps
`include "cpu_defs.svh"

module execute_stage (
    input  logic               aclk,
    input  logic               rst_n,
    id_ex_if.dst               ex,
    wb_bus_if.dst              wb,
    ex_mem_if.src              mem,
    output logic               branch_taken,
    output cpu_pkg::word_t     branch_target,
    output logic               ex_mem_read,
    output cpu_pkg::reg_addr_t ex_dst
);
    import cpu_pkg::*;

    logic  mem_fwd_ok;
    logic  wb_fwd_ok;
    word_t opa;
    word_t opb;
    word_t alu_b;
    word_t alu_y;
    logic  equal;

    // a load in memory never feeds execute directly, the stall prevents it
    assign mem_fwd_ok = mem.valid && mem.reg_write && (mem.dest != '0);
    assign wb_fwd_ok  = wb.valid && wb.reg_write && (wb.dest != '0);

    assign opa = (mem_fwd_ok && (mem.dest == ex.rs)) ? mem.result :
                 (wb_fwd_ok && (wb.dest == ex.rs))   ? wb.result  : ex.a;
    assign opb = (mem_fwd_ok && (mem.dest == ex.rt)) ? mem.result :
                 (wb_fwd_ok && (wb.dest == ex.rt))   ? wb.result  : ex.b;

    assign alu_b = ex.use_imm ? ex.imm : opb;

    always_comb begin
        case (ex.alu_op)
            `ALU_SUB: alu_y = opa - alu_b;
            `ALU_AND: alu_y = opa & alu_b;
            `ALU_OR:  alu_y = opa | alu_b;
            `ALU_SLT: alu_y = {31'b0, $signed(opa) < $signed(alu_b)};
            `ALU_LUI: alu_y = {alu_b[15:0], 16'b0};
            default:  alu_y = opa + alu_b;               // add, load and store address
        endcase
    end

    assign equal         = (opa == opb);
    assign branch_taken  = ex.valid && ((ex.branch_eq && equal) || (ex.branch_ne && !equal));
    assign branch_target = ex.pc + 32'd4 + {ex.imm[29:0], 2'b00};

    assign ex_mem_read = ex.valid && ex.mem_read;        // to hazard unit
    assign ex_dst      = ex.dest;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            mem.valid     <= 1'b0;
            mem.reg_write <= 1'b0;
            mem.mem_read  <= 1'b0;
            mem.mem_write <= 1'b0;
        end else begin
            mem.valid     <= ex.valid;
            mem.reg_write <= ex.valid && ex.reg_write;
            mem.mem_read  <= ex.valid && ex.mem_read;
            mem.mem_write <= ex.valid && ex.mem_write;
        end
    end

    always_ff @(posedge aclk) begin
        mem.pc         <= ex.pc;
        mem.result     <= alu_y;
        mem.store_data <= opb;                           // forwarded rt
        mem.dest       <= ex.dest;
    end

endmodule

// File: list.f
+incdir+common
common/cpu_pkg.sv
common/pipe_ifs.sv
verilog/hazard_ctrl.sv
verilog/fetch_stage.sv
decode/reg_file.sv
decode/decode_stage.sv
execute/execute_stage.sv
verilog/mem_wb_stage.sv
verilog/cpu_top.sv
sim/cpu_props.sv
sim/tb_cpu.sv

// File: sim/cpu_props.sv
// bound concurrent checks on the core data port and writeback trace
`timescale 1ns/1ps

module cpu_props (
    input logic               aclk,
    input logic               rst_n,
    input logic               data_en,
    input logic               data_we,
    input cpu_pkg::word_t     data_addr,
    input logic [3:0]         debug_wb_rf_wen,
    input cpu_pkg::reg_addr_t debug_wb_rf_wnum
);

    int fail_count = 0;                                  // failed assertions so far

    we_needs_en: assert property (@(posedge aclk) disable iff (!rst_n) data_we |-> data_en)
        else begin
            fail_count++;
            $error("data_we high without data_en");
        end

    addr_aligned: assert property (@(posedge aclk) disable iff (!rst_n)
        data_en |-> (data_addr[1:0] == 2'b00))
        else begin
            fail_count++;
            $error("data access to an unaligned address");
        end

    wen_nonzero_reg: assert property (@(posedge aclk) disable iff (!rst_n)
        (debug_wb_rf_wen != 4'h0) |-> (debug_wb_rf_wnum != '0))
        else begin
            fail_count++;
            $error("register write reported for r0");
        end

    quiet_in_reset: assert property (@(posedge aclk) !rst_n |-> (debug_wb_rf_wen == 4'h0))
        else begin
            fail_count++;
            $error("register write reported during reset");
        end

endmodule

bind cpu_top cpu_props u_props (
    .aclk, .rst_n, .data_en, .data_we, .data_addr, .debug_wb_rf_wen, .debug_wb_rf_wnum
);

// File: sim/tb_cpu.sv
// pipelined core testbench with random program, memory models, reference model and checks
`timescale 1ns/1ps
`include "cpu_defs.svh"

module tb_cpu;
    import cpu_pkg::*;

    localparam int PERIOD     = 40;
    localparam int PROG_LEN   = 200;
    localparam int LAST       = PROG_LEN - 1;            // closing self loop
    localparam int MAX_CYCLES = 10 + PROG_LEN * 4 + 100;

    logic      aclk;
    logic      rst_n;
    word_t     inst_addr;
    word_t     inst_rdata;
    logic      data_en;
    logic      data_we;
    word_t     data_addr;
    word_t     data_wdata;
    word_t     data_rdata;
    word_t     debug_wb_pc;
    word_t     debug_wb_rf_wdata;
    logic [3:0] debug_wb_rf_wen;
    reg_addr_t debug_wb_rf_wnum;

    word_t     imem [256];
    word_t     dmem [64];
    word_t     inst_index;
    logic      is_consumer [256];                        // reads a load result at once
    logic      is_target [256];                          // reached by a taken branch
    word_t     exp_pc [$];
    reg_addr_t exp_reg [$];
    word_t     exp_val [$];
    word_t     exp_sa [$];
    word_t     exp_sd [$];
    word_t     e_pc;
    reg_addr_t e_reg;
    word_t     e_val;
    word_t     pidx;
    int        tid;
    int        test_err [1:6];
    string     test_name [1:6];
    int        exp_writes;
    int        exp_stores;
    int        exp_cons;
    int        wr_count;
    int        st_count;
    int        cons_seen;
    integer    seed;

    cpu_top uut (
        .aclk, .rst_n, .inst_addr, .inst_rdata,
        .data_en, .data_we, .data_addr, .data_wdata, .data_rdata,
        .debug_wb_pc, .debug_wb_rf_wdata, .debug_wb_rf_wen, .debug_wb_rf_wnum
    );

    initial begin
        aclk = 1'b0;
        forever #(PERIOD / 2) aclk = ~aclk;
    end

    assign inst_index = (inst_addr - `RESET_PC) >> 2;
    assign inst_rdata = (inst_index < 256) ? imem[inst_index[7:0]] : '0;  // no-op past the program
    assign data_rdata = dmem[data_addr[7:2]];

    function automatic int pick(int n);
        return {$random(seed)} % n;
    endfunction

    function automatic word_t r_format(reg_addr_t rs, reg_addr_t rt, reg_addr_t rd,
                                       logic [5:0] fn);
        return {`OP_SPECIAL, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic word_t i_format(logic [5:0] op, reg_addr_t rs, reg_addr_t rt,
                                       logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t fill_word(int addr);
        return word_t'(addr) * 32'h9e37_79b1 ^ 32'h0bad_cafe;   // spreads every address bit
    endfunction

    task automatic check(input word_t got, input word_t exp, input int test, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t ns: test %0d %s is %h, expected %h",
                     $time, test, what, got, exp);
            test_err[test]++;
        end
    endtask

    task automatic init_memories();
        foreach (imem[j]) begin
            imem[j]        = '0;
            is_consumer[j] = 1'b0;
            is_target[j]   = 1'b0;
        end
        foreach (dmem[j])
            dmem[j] = fill_word(j * 4);
    endtask

    task automatic build_program();
        int          i;
        int          k;
        reg_addr_t   s;
        reg_addr_t   t;
        reg_addr_t   d;
        logic [15:0] imm;
        i = 0;
        while (i < LAST) begin
            s   = reg_addr_t'(pick(8));                  // few registers give many hazards
            t   = reg_addr_t'(pick(8));
            d   = reg_addr_t'(pick(8));
            imm = 16'(pick(65536));
            case (pick(12))
                0: imem[i] = r_format(s, t, d, `FN_ADDU);
                1: imem[i] = r_format(s, t, d, `FN_SUBU);
                2: imem[i] = r_format(s, t, d, `FN_AND);
                3: imem[i] = r_format(s, t, d, `FN_OR);
                4: imem[i] = r_format(s, t, d, `FN_SLT);
                5: imem[i] = i_format(`OP_ADDIU, s, d, imm);
                6: imem[i] = i_format(`OP_ORI, s, d, imm);
                7: imem[i] = i_format(`OP_LUI, 5'd0, d, imm);
                8: begin                                 // load followed by an immediate consumer
                    d       = reg_addr_t'(pick(7) + 1);
                    imem[i] = i_format(`OP_LW, 5'd0, d, 16'(pick(64) * 4));
                    if (i + 1 < LAST) begin
                        i++;
                        imem[i]        = r_format(d, t, reg_addr_t'(pick(7) + 1), `FN_ADDU);
                        is_consumer[i] = 1'b1;
                    end
                end
                9: imem[i] = i_format(`OP_SW, 5'd0, t, 16'(pick(64) * 4));
                10: begin
                    k = pick(4);
                    if (i + 1 + k > LAST)
                        k = LAST - i - 1;
                    imem[i] = i_format(pick(2) ? `OP_BEQ : `OP_BNE, s, t, 16'(k));
                end
                default: imem[i] = {6'h3f, imm, 10'd0};  // unknown opcode
            endcase
            i++;
        end
        imem[LAST] = i_format(`OP_BEQ, 5'd0, 5'd0, 16'hffff);
    endtask

    // in-order instruction model yielding the write and store traces
    task automatic run_model();
        word_t     rf [32];
        word_t     mm [64];
        word_t     ins;
        word_t     a;
        word_t     b;
        word_t     se;
        word_t     val;
        word_t     addr;
        reg_addr_t dst;
        logic      wr;
        int        idx;
        int        nxt;
        foreach (rf[j])
            rf[j] = '0;
        foreach (mm[j])
            mm[j] = fill_word(j * 4);
        idx = 0;
        while (idx != LAST) begin
            ins  = imem[idx];
            a    = rf[ins[25:21]];
            b    = rf[ins[20:16]];
            se   = {{16{ins[15]}}, ins[15:0]};
            addr = a + se;
            val  = '0;
            wr   = 1'b1;
            dst  = ins[20:16];
            nxt  = idx + 1;
            case (ins[31:26])
                `OP_SPECIAL: begin
                    dst = ins[15:11];
                    case (ins[5:0])
                        `FN_ADDU: val = a + b;
                        `FN_SUBU: val = a - b;
                        `FN_AND:  val = a & b;
                        `FN_OR:   val = a | b;
                        `FN_SLT:  val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default:  wr = 1'b0;
                    endcase
                end
                `OP_ADDIU: val = a + se;
                `OP_ORI:   val = a | {16'b0, ins[15:0]};
                `OP_LUI:   val = {ins[15:0], 16'b0};
                `OP_LW:    val = mm[addr[7:2]];
                `OP_SW: begin
                    wr            = 1'b0;
                    mm[addr[7:2]] = b;
                    exp_sa.push_back(addr);
                    exp_sd.push_back(b);
                end
                `OP_BEQ, `OP_BNE: begin
                    wr = 1'b0;
                    if ((a == b) == (ins[31:26] == `OP_BEQ)) begin
                        nxt            = idx + 1 + int'($signed(ins[15:0]));
                        is_target[nxt] = 1'b1;
                    end
                end
                default: wr = 1'b0;
            endcase
            if (wr && (dst != '0)) begin
                rf[dst] = val;
                exp_pc.push_back(`RESET_PC + word_t'(idx * 4));
                exp_reg.push_back(dst);
                exp_val.push_back(val);
                if (is_consumer[idx])
                    exp_cons++;
            end
            idx = nxt;
        end
        exp_writes = exp_pc.size();
        exp_stores = exp_sa.size();
    endtask

    // trace and store monitor sampled mid-cycle
    always @(negedge aclk) begin
        if (debug_wb_rf_wen != 4'h0) begin
            if (wr_count == 0)
                check(word_t'(debug_wb_pc >= `RESET_PC && debug_wb_pc <= `RESET_PC + 4 * LAST),
                      1, 5, "first retired pc inside program");
            if (exp_pc.size() == 0) begin
                $display("unexpected register write to r%0d from pc %h at %0t ns",
                         debug_wb_rf_wnum, debug_wb_pc, $time);
                test_err[1]++;
            end else begin
                e_pc  = exp_pc.pop_front();
                e_reg = exp_reg.pop_front();
                e_val = exp_val.pop_front();
                pidx  = (e_pc - `RESET_PC) >> 2;
                tid   = is_consumer[pidx[7:0]] ? 3 : (is_target[pidx[7:0]] ? 4 : 1);
                check(debug_wb_pc, e_pc, tid, "retired pc");
                check(word_t'(debug_wb_rf_wnum), word_t'(e_reg), tid, "retired register");
                check(debug_wb_rf_wdata, e_val, tid, "retired value");
                if (tid == 3)
                    cons_seen++;
            end
            wr_count++;
        end
        if (data_en && data_we) begin
            if (exp_sa.size() == 0) begin
                $display("unexpected store to %h at %0t ns", data_addr, $time);
                test_err[2]++;
            end else begin
                check(data_addr, exp_sa.pop_front(), 2, "store address");
                check(data_wdata, exp_sd.pop_front(), 2, "store data");
            end
            dmem[data_addr[7:2]] = data_wdata;
            st_count++;
        end
    end

    initial begin
        int fails;
        int prop_fails;
        seed      = 12;
        rst_n     = 1'b0;
        wr_count  = 0;
        st_count  = 0;
        cons_seen = 0;
        exp_cons  = 0;
        foreach (test_err[t])
            test_err[t] = 0;
        test_name[1] = "register write trace";
        test_name[2] = "store trace";
        test_name[3] = "load-use consumers";
        test_name[4] = "branch targets";
        test_name[5] = "quiet after reset";
        test_name[6] = "write and store counts";
        init_memories();
        build_program();
        run_model();
        repeat (10) @(negedge aclk);
        rst_n = 1'b1;
        check(inst_addr, `RESET_PC, 5, "first fetch address");
        repeat (2) begin                                 // first instruction not yet in memory stage
            @(negedge aclk);
            check(word_t'(data_en), 0, 5, "data_en after reset");
            check(word_t'(debug_wb_rf_wen), 0, 5, "debug_wb_rf_wen after reset");
        end
        wait (wr_count >= exp_writes && st_count >= exp_stores);
        repeat (20) @(negedge aclk);                     // room for stray writes
        check(word_t'(wr_count), word_t'(exp_writes), 6, "register write count");
        check(word_t'(st_count), word_t'(exp_stores), 6, "store count");
        check(word_t'(cons_seen), word_t'(exp_cons), 3, "load consumers retired");
        prop_fails = uut.u_props.fail_count;
        fails = 0;
        for (int t = 1; t <= 6; t++) begin
            $display("test %0d %s: %s", t, test_name[t], (test_err[t] == 0) ? "ok" : "failed");
            if (test_err[t] != 0)
                fails++;
        end
        $display("%0d of 6 tests ok, %0d writes, %0d stores, %0d property failures",
                 6 - fails, wr_count, st_count, prop_fails);
        if (fails == 0 && prop_fails == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(MAX_CYCLES * PERIOD);
        $display("timeout: the program did not finish retiring within %0d cycles", MAX_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: verilog/cpu_top.sv
// core top level wiring the five stages, hazard control and memory ports
`timescale 1ns/1ps

module cpu_top (
    input  logic               aclk,
    input  logic               rst_n,
    output cpu_pkg::word_t     inst_addr,
    input  cpu_pkg::word_t     inst_rdata,
    output logic               data_en,
    output logic               data_we,
    output cpu_pkg::word_t     data_addr,
    output cpu_pkg::word_t     data_wdata,
    input  cpu_pkg::word_t     data_rdata,
    output cpu_pkg::word_t     debug_wb_pc,
    output cpu_pkg::word_t     debug_wb_rf_wdata,
    output logic [3:0]         debug_wb_rf_wen,
    output cpu_pkg::reg_addr_t debug_wb_rf_wnum
);
    import cpu_pkg::*;

    word_t     if_pc;
    word_t     if_instr;
    logic      if_valid;
    reg_addr_t id_rs;
    reg_addr_t id_rt;
    logic      id_use_rs;
    logic      id_use_rt;
    logic      ex_mem_read;
    reg_addr_t ex_dst;
    logic      branch_taken;
    word_t     branch_target;
    logic      stall;                                     // load-use hold
    logic      flush;                                     // taken branch

    id_ex_if  id_ex ();
    ex_mem_if ex_mem ();
    wb_bus_if wb_bus ();

    hazard_ctrl u_hazard (
        .id_rs, .id_rt, .id_use_rs, .id_use_rt,
        .ex_mem_read, .ex_dst, .branch_taken,
        .stall, .flush
    );

    fetch_stage u_fetch (
        .aclk, .rst_n, .stall, .flush,
        .branch_taken, .branch_target,
        .inst_addr, .inst_rdata,
        .if_pc, .if_instr, .if_valid
    );

    decode_stage u_decode (
        .aclk, .rst_n, .stall, .flush,
        .if_valid, .if_pc, .if_instr,
        .wb   (wb_bus.dst),
        .ex   (id_ex.src),
        .id_rs, .id_rt, .id_use_rs, .id_use_rt
    );

    execute_stage u_execute (
        .aclk, .rst_n,
        .ex   (id_ex.dst),
        .wb   (wb_bus.dst),
        .mem  (ex_mem.src),
        .branch_taken, .branch_target, .ex_mem_read, .ex_dst
    );

    mem_wb_stage u_mem_wb (
        .aclk, .rst_n,
        .mem  (ex_mem.dst),
        .data_en, .data_we, .data_addr, .data_wdata, .data_rdata,
        .wb   (wb_bus.src),
        .debug_wb_pc, .debug_wb_rf_wdata, .debug_wb_rf_wen, .debug_wb_rf_wnum
    );

endmodule

// File: verilog/fetch_stage.sv
// program counter and fetch-to-decode pipeline register
`timescale 1ns/1ps
`include "cpu_defs.svh"

module fetch_stage (
    input  logic           aclk,
    input  logic           rst_n,
    input  logic           stall,
    input  logic           flush,
    input  logic           branch_taken,
    input  cpu_pkg::word_t branch_target,
    output cpu_pkg::word_t inst_addr,
    input  cpu_pkg::word_t inst_rdata,
    output cpu_pkg::word_t if_pc,
    output cpu_pkg::word_t if_instr,
    output logic           if_valid
);
    import cpu_pkg::*;

    word_t pc;

    assign inst_addr = pc;                               // instruction memory answers in-cycle

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            pc       <= `RESET_PC;
            if_valid <= 1'b0;
        end else begin
            if (branch_taken)
                pc <= branch_target;                     // no delay slot
            else if (!stall)
                pc <= pc + 32'd4;
            if (flush)
                if_valid <= 1'b0;
            else if (!stall)
                if_valid <= 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (!stall) begin
            if_pc    <= pc;
            if_instr <= inst_rdata;
        end
    end

endmodule

// File: verilog/hazard_ctrl.sv
// load-use stall detection and branch flush generation
`timescale 1ns/1ps

module hazard_ctrl (
    input  cpu_pkg::reg_addr_t id_rs,
    input  cpu_pkg::reg_addr_t id_rt,
    input  logic               id_use_rs,
    input  logic               id_use_rt,
    input  logic               ex_mem_read,
    input  cpu_pkg::reg_addr_t ex_dst,
    input  logic               branch_taken,
    output logic               stall,
    output logic               flush
);

    logic rs_hit;
    logic rt_hit;
    logic load_use;

    // load result not ready until writeback, so hold decode one cycle
    assign rs_hit   = id_use_rs && (id_rs == ex_dst);
    assign rt_hit   = id_use_rt && (id_rt == ex_dst);
    assign load_use = ex_mem_read && (ex_dst != '0) && (rs_hit || rt_hit);

    assign flush = branch_taken;
    assign stall = load_use && !branch_taken;           // flush wins

endmodule

// File: verilog/mem_wb_stage.sv
// data port drive, memory-to-writeback register and debug trace outputs
`timescale 1ns/1ps

module mem_wb_stage (
    input  logic               aclk,
    input  logic               rst_n,
    ex_mem_if.dst              mem,
    output logic               data_en,
    output logic               data_we,
    output cpu_pkg::word_t     data_addr,
    output cpu_pkg::word_t     data_wdata,
    input  cpu_pkg::word_t     data_rdata,
    wb_bus_if.src              wb,
    output cpu_pkg::word_t     debug_wb_pc,
    output cpu_pkg::word_t     debug_wb_rf_wdata,
    output logic [3:0]         debug_wb_rf_wen,
    output cpu_pkg::reg_addr_t debug_wb_rf_wnum
);
    import cpu_pkg::*;

    word_t wb_pc;

    // single-cycle strobe, read data back in the same cycle
    assign data_en    = mem.valid && (mem.mem_read || mem.mem_write);
    assign data_we    = mem.valid && mem.mem_write;
    assign data_addr  = mem.result;
    assign data_wdata = mem.store_data;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            wb.valid     <= 1'b0;
            wb.reg_write <= 1'b0;
        end else begin
            wb.valid     <= mem.valid;
            wb.reg_write <= mem.valid && mem.reg_write;
        end
    end

    always_ff @(posedge aclk) begin
        wb_pc     <= mem.pc;
        wb.dest   <= mem.dest;
        wb.result <= mem.mem_read ? data_rdata : mem.result;
    end

    assign debug_wb_pc       = wb_pc;
    assign debug_wb_rf_wdata = wb.result;
    assign debug_wb_rf_wnum  = wb.dest;
    assign debug_wb_rf_wen   = (wb.valid && wb.reg_write && (wb.dest != '0)) ? 4'hf : 4'h0;

endmodule
